// File: build.f
+incdir+verification
logic/interpPkg.sv
logic/ringSequencer.sv
logic/sampleFifo.sv
logic/bilinearInterp.sv
logic/ringInterpTop.sv
verification/ringInterpTb.sv

// File: logic/bilinearInterp.sv
`timescale 1ns/1ps

module bilinearInterp (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 inValid,
  input  interpPkg::sampleTokT inTok,
  output logic                 inReady,
  output logic                 resValid,
  output interpPkg::sampleResT res,
  input  logic                 resReady
);
  import interpPkg::*;

  // 8.8 weights per ring, near and far side of the sample point
  localparam logic [7:0] NearTab [4] = '{8'h6A, 8'hD4, 8'h3E, 8'hA8};
  localparam logic [7:0] FarTab  [4] = '{8'h96, 8'h2C, 8'hC2, 8'h58};

  typedef struct packed {
    logic [15:0] oneMinusDx;
    logic [15:0] oneMinusDy;
    logic [15:0] dx;
    logic [15:0] dy;
  } weightT;

  weightT      wSel;
  logic [15:0] nearW;
  logic [15:0] farW;
  logic        advance;

  logic              s1Valid;
  logic              s1Last;
  logic [3:0][31:0]  s1Weight;  // a, b, c, d order
  pixelT [3:0]       s1Pix;

  logic              s2Valid;
  logic              s2Last;
  logic [3:0][31:0]  s2Term;

  logic [15:0]       sum;
  logic              sumLast;

  // one enable for every stage, so a stall freezes the whole pipe
  assign advance = !resValid || resReady;
  assign inReady = advance;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // weight lookup by ring and angle
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign nearW = {8'h00, NearTab[inTok.ring]};
  assign farW  = {8'h00, FarTab[inTok.ring]};

  always_comb begin
    case (inTok.angle)
      angNE: wSel = '{oneMinusDx: nearW, oneMinusDy: farW, dx: farW, dy: nearW};
      angNW: wSel = '{oneMinusDx: nearW, oneMinusDy: nearW, dx: farW, dy: farW};
      angSW: wSel = '{oneMinusDx: farW, oneMinusDy: nearW, dx: nearW, dy: farW};
      default: wSel = '{oneMinusDx: farW, oneMinusDy: farW, dx: nearW, dy: nearW};
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // three stage datapath
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (rst) begin
      s1Valid  <= 1'b0;
      s2Valid  <= 1'b0;
      resValid <= 1'b0;
    end else if (advance) begin
      s1Valid  <= inValid;
      s2Valid  <= s1Valid;
      resValid <= s2Valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      // stage 1, weight products
      s1Weight[0] <= wSel.oneMinusDx * wSel.oneMinusDy;
      s1Weight[1] <= wSel.dx * wSel.oneMinusDy;
      s1Weight[2] <= wSel.dy * wSel.oneMinusDx;
      s1Weight[3] <= wSel.dx * wSel.dy;
      s1Pix[0]    <= inTok.a;
      s1Pix[1]    <= inTok.b;
      s1Pix[2]    <= inTok.c;
      s1Pix[3]    <= inTok.d;
      s1Last      <= inTok.last;

      // stage 2, weighted pixels
      for (int i = 0; i < 4; i++) begin
        s2Term[i] <= s1Weight[i][23:8] * {s1Pix[i], 8'h00};
      end
      s2Last <= s1Last;

      // stage 3, sum wraps at 16 bits
      sum <= s2Term[0][23:8] + s2Term[1][23:8] + s2Term[2][23:8] + s2Term[3][23:8];
      sumLast <= s2Last;
    end
  end

  // round up only above half, carry out of the high byte is dropped
  always_comb begin
    res.intensity = (sum[7:0] > 8'h80) ? sum[15:8] + 8'd1 : sum[15:8];
    res.zeroFrac  = (sum[7:0] == 8'h00);
    res.last      = sumLast;
  end

endmodule

// File: logic/interpPkg.sv
package interpPkg;

  typedef logic [7:0] pixelT;  // unsigned intensity
  typedef logic [1:0] ringT;   // weight table holds four rings

  // diagonal sample directions, counter-clockwise from 45 degrees
  typedef enum logic [1:0] {
    angNE = 2'd0,  // 45
    angNW = 2'd1,  // 135
    angSW = 2'd2,  // 225
    angSE = 2'd3   // 315
  } angleT;

  typedef enum logic {
    seqIdle  = 1'b0,
    seqIssue = 1'b1
  } seqStateT;

  // 3x3 patch, pRC with row 0 at the top
  typedef struct packed {
    ringT  ring;
    pixelT p00;
    pixelT p01;
    pixelT p02;
    pixelT p10;
    pixelT p11;
    pixelT p12;
    pixelT p20;
    pixelT p21;
    pixelT p22;
  } patchJobT;

  typedef struct packed {
    ringT  ring;
    angleT angle;
    pixelT a;     // center
    pixelT b;     // horizontal neighbor
    pixelT c;     // vertical neighbor
    pixelT d;     // diagonal
    logic  last;  // fourth token of a job
  } sampleTokT;

  typedef struct packed {
    pixelT intensity;
    logic  zeroFrac;
    logic  last;
  } sampleResT;

endpackage

// File: logic/ringInterpTop.sv
`timescale 1ns/1ps

module ringInterpTop #(
  parameter int FifoDepth = 4
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 jobValid,
  input  interpPkg::patchJobT  job,
  output logic                 jobReady,
  output logic                 resValid,
  output interpPkg::sampleResT res,
  input  logic                 resReady
);
  import interpPkg::*;

  // sequencer to fifo
  logic      tokValid;
  sampleTokT tok;
  logic      tokReady;

  // fifo to interpolator
  logic      fifoValid;
  sampleTokT fifoTok;
  logic      fifoReady;

  ringSequencer seq (
    .clk      (clk),
    .rst      (rst),
    .jobValid (jobValid),
    .job      (job),
    .jobReady (jobReady),
    .tokValid (tokValid),
    .tok      (tok),
    .tokReady (tokReady)
  );

  sampleFifo #(
    .FifoDepth (FifoDepth)
  ) fifo (
    .clk      (clk),
    .rst      (rst),
    .inValid  (tokValid),
    .inTok    (tok),
    .inReady  (tokReady),
    .outValid (fifoValid),
    .outTok   (fifoTok),
    .outReady (fifoReady)
  );

  bilinearInterp interp (
    .clk      (clk),
    .rst      (rst),
    .inValid  (fifoValid),
    .inTok    (fifoTok),
    .inReady  (fifoReady),
    .resValid (resValid),
    .res      (res),
    .resReady (resReady)
  );

endmodule

// File: logic/ringSequencer.sv
`timescale 1ns/1ps

module ringSequencer (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 jobValid,
  input  interpPkg::patchJobT  job,
  output logic                 jobReady,
  output logic                 tokValid,
  output interpPkg::sampleTokT tok,
  input  logic                 tokReady
);
  import interpPkg::*;

  seqStateT state;
  angleT    angle;
  patchJobT jobReg;

  logic jobTake;
  logic tokTake;

  assign jobReady = (state == seqIdle);
  assign tokValid = (state == seqIssue);
  assign jobTake  = jobValid && jobReady;
  assign tokTake  = tokValid && tokReady;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // job capture and angle walk
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (jobTake) begin
      jobReg <= job;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= seqIdle;
      angle <= angNE;
    end else begin
      case (state)
        seqIdle: begin
          if (jobTake) begin
            state <= seqIssue;
            angle <= angNE;  // first token next cycle
          end
        end
        seqIssue: begin
          if (tokTake) begin
            if (angle == angSE) begin
              state <= seqIdle;
            end else begin
              angle <= angleT'(angle + 2'd1);
            end
          end
        end
        default: begin
          state <= seqIdle;
        end
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // quad selection
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    tok.ring  = jobReg.ring;
    tok.angle = angle;
    tok.a     = jobReg.p11;
    tok.last  = (angle == angSE);
    case (angle)
      angNE: begin
        tok.b = jobReg.p12;
        tok.c = jobReg.p01;
        tok.d = jobReg.p02;
      end
      angNW: begin
        tok.b = jobReg.p10;
        tok.c = jobReg.p01;
        tok.d = jobReg.p00;
      end
      angSW: begin
        tok.b = jobReg.p10;
        tok.c = jobReg.p21;
        tok.d = jobReg.p20;
      end
      default: begin  // angSE
        tok.b = jobReg.p12;
        tok.c = jobReg.p21;
        tok.d = jobReg.p22;
      end
    endcase
  end

endmodule

// File: logic/sampleFifo.sv
`timescale 1ns/1ps

module sampleFifo #(
  parameter int FifoDepth = 4
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 inValid,
  input  interpPkg::sampleTokT inTok,
  output logic                 inReady,
  output logic                 outValid,
  output interpPkg::sampleTokT outTok,
  input  logic                 outReady
);
  import interpPkg::*;

  localparam int PtrW = $clog2(FifoDepth);
  localparam logic [PtrW:0] FullCount = (PtrW + 1)'(FifoDepth);

  sampleTokT mem [FifoDepth];

  logic [PtrW-1:0] wrPtr;
  logic [PtrW-1:0] rdPtr;
  logic [PtrW:0]   count;
  logic            push;
  logic            pop;

  assign outValid = (count != '0);
  assign outTok   = mem[rdPtr];  // head entry
  // a full buffer still takes a token when the head leaves this cycle
  assign inReady  = (count != FullCount) || outReady;
  assign push     = inValid && inReady;
  assign pop      = outValid && outReady;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wrPtr] <= inTok;
    end
  end

  // pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (pop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      case ({push, pop})
        2'b10: begin
          count <= count + 1'b1;
        end
        2'b01: begin
          count <= count - 1'b1;
        end
        default: begin
          count <= count;  // idle or pass-through
        end
      endcase
    end
  end

endmodule

// File: run.sh
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module ringInterpTb -f build.f -o ringInterpSim &&
  ./obj_dir/ringInterpSim | awk '{ print } $0 == "Result: PASSED" { ok = 1 } END { exit !ok }' &&
  echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: verification/ringInterpModel.svh
`ifndef RING_INTERP_MODEL_SVH
`define RING_INTERP_MODEL_SVH

typedef struct packed {
  logic     rnd;  // pixels drawn from the LFSR
  patchJobT job;
} stimT;

localparam int NumJobs = 10;

stimT        stimTab [NumJobs];
logic [15:0] lfsr = 16'd30;

// fibonacci, x^16 + x^14 + x^13 + x^11 + 1
function automatic logic takeBit();
  lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
  return lfsr[0];
endfunction

function automatic pixelT randPixel();
  pixelT p;
  p = '0;
  for (int i = 0; i < 8; i++) begin
    p = {p[6:0], takeBit()};
  end
  return p;
endfunction

// far weight is the complement of the near one, both 8.8
function automatic logic [15:0] ringWeight(ringT r, logic far);
  logic [7:0] n;
  case (r)
    2'd0: n = 8'h6A;
    2'd1: n = 8'hD4;
    2'd2: n = 8'h3E;
    default: n = 8'hA8;
  endcase
  return far ? 16'h0100 - {8'h00, n} : {8'h00, n};
endfunction

function automatic sampleResT modelSample(patchJobT j, angleT ang);
  logic [15:0] n, f, omx, omy, dx, dy;
  logic [15:0] w [4];
  pixelT       px [4];
  logic [31:0] prod;
  logic [15:0] sum;
  sampleResT   r;
  n = ringWeight(j.ring, 1'b0);
  f = ringWeight(j.ring, 1'b1);
  px[0] = j.p11;
  case (ang)
    angNE: begin
      {omx, omy, dx, dy} = {n, f, f, n};
      {px[1], px[2], px[3]} = {j.p12, j.p01, j.p02};
    end
    angNW: begin
      {omx, omy, dx, dy} = {n, n, f, f};
      {px[1], px[2], px[3]} = {j.p10, j.p01, j.p00};
    end
    angSW: begin
      {omx, omy, dx, dy} = {f, n, n, f};
      {px[1], px[2], px[3]} = {j.p10, j.p21, j.p20};
    end
    default: begin
      {omx, omy, dx, dy} = {f, f, n, n};
      {px[1], px[2], px[3]} = {j.p12, j.p21, j.p22};
    end
  endcase
  prod = omx * omy;
  w[0] = prod[23:8];
  prod = dx * omy;
  w[1] = prod[23:8];
  prod = dy * omx;
  w[2] = prod[23:8];
  prod = dx * dy;
  w[3] = prod[23:8];
  sum = '0;
  for (int i = 0; i < 4; i++) begin
    prod = w[i] * {px[i], 8'h00};
    sum = sum + prod[23:8];  // wraps at 16 bits
  end
  r.intensity = sum[15:8] + {7'd0, (sum[7:0] > 8'h80)};
  r.zeroFrac  = (sum[7:0] == 8'h00);
  r.last      = (ang == angSE);
  return r;
endfunction

function automatic patchJobT mkJob(ringT r, logic [71:0] pix);
  return patchJobT'({r, pix});  // pix runs p00 first down to p22
endfunction

task automatic loadTable();
  logic [71:0] pix;
  stimTab[0] = '{1'b0, mkJob(2'd0, {9{8'h80}})};  // flat
  stimTab[1] = '{1'b0, mkJob(2'd1, {9{8'h00}})};
  stimTab[2] = '{1'b0, mkJob(2'd2, {9{8'hC5}})};
  stimTab[3] = '{1'b0, mkJob(2'd3, {9{8'hFF}})};
  stimTab[4] = '{1'b0, mkJob(2'd1, 72'h11_22_33_44_55_66_77_88_99)};  // all distinct
  stimTab[5] = '{1'b0, mkJob(2'd2, 72'h00_FF_00_FF_00_FF_00_FF_00)};  // full range
  stimTab[6] = '{1'b1, mkJob(2'd0, '0)};
  stimTab[7] = '{1'b1, mkJob(2'd1, '0)};
  stimTab[8] = '{1'b1, mkJob(2'd2, '0)};
  stimTab[9] = '{1'b1, mkJob(2'd3, '0)};
  for (int i = 0; i < NumJobs; i++) begin
    if (stimTab[i].rnd) begin
      pix = '0;
      for (int k = 0; k < 9; k++) begin
        pix = {pix[63:0], randPixel()};
      end
      stimTab[i].job = mkJob(stimTab[i].job.ring, pix);
    end
  end
endtask

`endif

// File: verification/ringInterpTb.sv
`timescale 1ns/1ps

module ringInterpTb;
  import interpPkg::*;

  localparam int HalfPeriod  = 4;
  localparam int ResetCycles = 16;

  logic      clk;
  logic      rst;
  logic      jobValid;
  patchJobT  job;
  logic      jobReady;
  logic      resValid;
  sampleResT res;
  logic      resReady;

  `include "ringInterpModel.svh"

  localparam int WatchCycles = NumJobs * 200;

  sampleResT expQ [$];
  int errCount   = 0;
  int checkCount = 0;
  int resCount   = 0;
  int jobsDone   = 0;
  int jobErrs    = 0;  // mismatches in the job being collected

  ringInterpTop #(
    .FifoDepth (4)
  ) dut (
    .clk      (clk),
    .rst      (rst),
    .jobValid (jobValid),
    .job      (job),
    .jobReady (jobReady),
    .resValid (resValid),
    .res      (res),
    .resReady (resReady)
  );

  initial begin
    clk = 1'b0;
    forever #(HalfPeriod) clk = ~clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // result checking
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic compareRes(string name, sampleResT got, sampleResT want);
    checkCount++;
    if (got !== want) begin
      errCount++;
      jobErrs++;
      $display("FAIL %s: got %h (intensity %h zeroFrac %h last %h) expected %h", name, got,
               got.intensity, got.zeroFrac, got.last, want);
    end
  endtask

  task automatic compareReady(int jobIdx, logic got, logic want);
    checkCount++;
    if (got !== want) begin
      errCount++;
      $display("FAIL jobReady after job %0d: got %h expected %h", jobIdx, got, want);
    end
  endtask

  task automatic takeResult(sampleResT got);
    sampleResT want;
    angleT     ang;
    int        jobIdx;
    if (expQ.size() == 0) begin
      errCount++;
      $display("a result came out while no job was outstanding");
      return;
    end
    want   = expQ.pop_front();
    jobIdx = resCount / 4;
    ang    = angleT'(resCount % 4);
    compareRes($sformatf("res job %0d %s", jobIdx, ang.name()), got, want);
    resCount++;
    if (resCount % 4 == 0) begin
      if (jobErrs == 0) begin
        $display("job %0d ring %0d: ok", jobIdx, stimTab[jobIdx].job.ring);
      end else begin
        $display("job %0d ring %0d: %0d wrong samples", jobIdx, stimTab[jobIdx].job.ring,
                 jobErrs);
      end
      jobErrs = 0;
      jobsDone++;
    end
  endtask

  // resReady toggles randomly for back-pressure
  initial begin
    wait (rst == 1'b0);
    forever begin
      @(negedge clk);
      resReady = takeBit();
      if (resValid && resReady) begin
        takeResult(res);  // transfer happens on the next rising edge
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // job driver and summary
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    bit accepted;
    rst      = 1'b1;
    jobValid = 1'b0;
    job      = '0;
    resReady = 1'b0;
    loadTable();
    repeat (ResetCycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < NumJobs; i++) begin
      job      = stimTab[i].job;
      jobValid = 1'b1;
      for (int k = 0; k < 4; k++) begin
        expQ.push_back(modelSample(stimTab[i].job, angleT'(k)));
      end
      accepted = 1'b0;
      while (!accepted) begin
        accepted = jobReady;
        @(negedge clk);
      end
      // sequencer is busy issuing one cycle after a take
      compareReady(i, jobReady, 1'b0);
    end
    jobValid = 1'b0;
    wait (jobsDone == NumJobs);
    repeat (10) @(negedge clk);  // room for stray results
    $display("jobs %0d/%0d, results %0d, checks %0d, errors %0d", jobsDone, NumJobs, resCount,
             checkCount, errCount);
    if (errCount == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    repeat (ResetCycles + WatchCycles) @(posedge clk);
    $display("timeout: only %0d of %0d jobs finished, %0d results never arrived", jobsDone,
             NumJobs, expQ.size());
    $display("Result: FAILED");
    $finish;
  end

endmodule
